// File: biu_pkg.sv
package biu_pkg;

    // physical address, 1 MB space
    typedef logic [19:0] bus_addr_t;

    typedef logic [7:0]  bus_data_t;   // one byte on ad
    typedef logic [15:0] cpu_word_t;   // core side data word

    // kind of bus cycle being run
    typedef enum logic [1:0] {
        mem_read,
        mem_write,
        int_ack
    } cyc_kind_t;

    // request as handed over by the core
    typedef struct packed {
        bus_addr_t addr;
        cpu_word_t wdata;
        logic      we;     // high for write
        logic      word;   // two bytes, low byte first
        logic      iom;    // high for i/o space
    } core_req_t;

    // one finished byte cycle, seen in T4
    typedef struct packed {
        bus_data_t data;   // byte taken from ad at end of T3
        cyc_kind_t kind;
        logic      hi;     // second byte of a pair
        logic      last;   // closes the whole cycle
    } byte_evt_t;

    // T-state machine of the bus
    typedef enum logic [2:0] {
        bs_idle,
        bs_t1,
        bs_t2,
        bs_t3,
        bs_t4,
        bs_held
    } bus_state_t;

    // interrupt acknowledge sequencer
    typedef enum logic [1:0] {
        ack_idle,
        ack_pend,       // waiting for the bus to run inta cycles
        ack_wait_low    // vector taken, wait for intr to drop
    } ack_state_t;

endpackage

// File: core_req_port.sv
`timescale 1ns/10ps

module core_req_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  biu_pkg::core_req_t  req_i,
    input  logic                byte_evt_valid_i,
    input  biu_pkg::byte_evt_t  byte_evt_i,
    output logic                req_pend_o,
    output biu_pkg::core_req_t  req_o,
    output logic                busy_o
);

    logic take_req;
    logic req_done;

    // a strobe while a request is pending is simply ignored
    assign take_req = req_valid_i && !req_pend_o;

    // final byte of a core cycle ends the request
    assign req_done = byte_evt_valid_i
                   && byte_evt_i.last
                   && (byte_evt_i.kind != biu_pkg::int_ack);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_pend_o <= 1'b0;
        end else begin
            if (take_req) begin
                req_pend_o <= 1'b1;
            end else if (req_done) begin
                req_pend_o <= 1'b0;
            end
        end
    end

    // request stays stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (take_req) begin
            req_o <= req_i;
        end
    end

    assign busy_o = req_pend_o;

endmodule

// File: intr_ack_seq.sv
`timescale 1ns/10ps

module intr_ack_seq (
    input  logic                clk,
    input  logic                rst,
    input  logic                intr_i,
    input  logic                byte_evt_valid_i,
    input  biu_pkg::byte_evt_t  byte_evt_i,
    output logic                ack_pend_o,
    output logic                vec_valid_o,
    output biu_pkg::bus_data_t  vec_o
);

    biu_pkg::ack_state_t state_q;
    biu_pkg::ack_state_t state_d;
    logic                ack_done;

    // second inta byte carries the vector
    assign ack_done = byte_evt_valid_i
                   && byte_evt_i.last
                   && (byte_evt_i.kind == biu_pkg::int_ack);

    always_comb begin
        state_d = state_q;
        case (state_q)
            biu_pkg::ack_idle: begin
                if (intr_i) begin
                    state_d = biu_pkg::ack_pend;
                end
            end
            biu_pkg::ack_pend: begin
                if (ack_done) begin
                    state_d = biu_pkg::ack_wait_low;
                end
            end
            biu_pkg::ack_wait_low: begin
                // one acknowledge per intr level
                if (!intr_i) begin
                    state_d = biu_pkg::ack_idle;
                end
            end
            default: state_d = biu_pkg::ack_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= biu_pkg::ack_idle;
            vec_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            vec_valid_o <= ack_done;   // one cycle after last T4
        end
    end

    always_ff @(posedge clk) begin
        if (ack_done) begin
            vec_o <= byte_evt_i.data;
        end
    end

    assign ack_pend_o = (state_q == biu_pkg::ack_pend);

endmodule

// File: bus_cycle_ctrl.sv
`timescale 1ns/10ps

module bus_cycle_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold_i,
    input  logic                ready_i,
    input  biu_pkg::bus_data_t  ad_i,
    input  logic                req_pend_i,
    input  biu_pkg::core_req_t  req_i,
    input  logic                ack_pend_i,
    output biu_pkg::bus_addr_t  a_o,
    output logic                ale_o,
    output logic                rd_n_o,
    output logic                wr_n_o,
    output logic                inta_n_o,
    output logic                den_n_o,
    output logic                dtr_o,
    output logic                iom_o,
    output biu_pkg::bus_data_t  ad_o,
    output logic                ad_oe_o,
    output logic                hlda_o,
    output logic                byte_evt_valid_o,
    output biu_pkg::byte_evt_t  byte_evt_o
);

    biu_pkg::bus_state_t state_q;
    biu_pkg::bus_state_t state_d;
    biu_pkg::cyc_kind_t  kind_q;
    logic                hi_q;       // running the second byte
    logic                two_q;      // cycle has two bytes
    biu_pkg::bus_data_t  rx_q;       // byte taken from ad
    biu_pkg::bus_addr_t  byte_addr;
    logic                is_ack;
    logic                strobe_act;
    logic                addr_phase;
    logic                last_byte;

    assign is_ack     = (kind_q == biu_pkg::int_ack);
    assign strobe_act = (state_q == biu_pkg::bs_t2) || (state_q == biu_pkg::bs_t3);
    assign last_byte  = !two_q || hi_q;

    // inta cycles put no address out
    assign addr_phase = (state_q == biu_pkg::bs_t1) && !is_ack;

    // A for the first byte, A+1 for the second
    assign byte_addr = req_i.addr + biu_pkg::bus_addr_t'(hi_q);

    // arbitration is only done in idle, hold wins, then inta, then core
    always_comb begin
        state_d = state_q;
        case (state_q)
            biu_pkg::bs_idle: begin
                if (hold_i) begin
                    state_d = biu_pkg::bs_held;
                end else if (ack_pend_i || req_pend_i) begin
                    state_d = biu_pkg::bs_t1;
                end
            end
            biu_pkg::bs_t1: state_d = biu_pkg::bs_t2;
            biu_pkg::bs_t2: state_d = biu_pkg::bs_t3;
            biu_pkg::bs_t3: begin
                if (ready_i) begin
                    state_d = biu_pkg::bs_t4;   // else one more wait state
                end
            end
            biu_pkg::bs_t4: begin
                // second byte follows straight away, no idle between
                state_d = last_byte ? biu_pkg::bs_idle : biu_pkg::bs_t1;
            end
            biu_pkg::bs_held: begin
                if (!hold_i) begin
                    state_d = biu_pkg::bs_idle;
                end
            end
            default: state_d = biu_pkg::bs_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= biu_pkg::bs_idle;
            kind_q  <= biu_pkg::mem_read;
            hi_q    <= 1'b0;
            two_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == biu_pkg::bs_idle) && (state_d == biu_pkg::bs_t1)) begin
                hi_q <= 1'b0;
                if (ack_pend_i) begin
                    kind_q <= biu_pkg::int_ack;
                    two_q  <= 1'b1;               // two inta pulses
                end else begin
                    kind_q <= req_i.we ? biu_pkg::mem_write : biu_pkg::mem_read;
                    two_q  <= req_i.word;
                end
            end else if (state_q == biu_pkg::bs_t4) begin
                hi_q <= !last_byte;
            end
        end
    end

    // sample at the T3 edge that ends the wait states
    always_ff @(posedge clk) begin
        if ((state_q == biu_pkg::bs_t3) && ready_i) begin
            rx_q <= ad_i;
        end
    end

    assign a_o   = is_ack ? '0 : byte_addr;
    assign ale_o = addr_phase;
    assign iom_o = is_ack || req_i.iom;

    // strobes low from T2 up to the last T3
    assign rd_n_o   = !(strobe_act && (kind_q == biu_pkg::mem_read));
    assign wr_n_o   = !(strobe_act && (kind_q == biu_pkg::mem_write));
    assign inta_n_o = !(strobe_act && is_ack);
    assign den_n_o  = !strobe_act;
    assign dtr_o    = !(strobe_act && (kind_q != biu_pkg::mem_write));   // low = into cpu

    // ad carries address in T1, write byte during the strobe
    assign ad_oe_o = addr_phase || (strobe_act && (kind_q == biu_pkg::mem_write));
    always_comb begin
        if (state_q == biu_pkg::bs_t1) begin
            ad_o = byte_addr[7:0];
        end else if (hi_q) begin
            ad_o = req_i.wdata[15:8];
        end else begin
            ad_o = req_i.wdata[7:0];
        end
    end

    assign hlda_o = (state_q == biu_pkg::bs_held);

    assign byte_evt_valid_o = (state_q == biu_pkg::bs_t4);
    assign byte_evt_o.data  = rx_q;
    assign byte_evt_o.kind  = kind_q;
    assign byte_evt_o.hi    = hi_q;
    assign byte_evt_o.last  = last_byte;

endmodule

// File: read_word_assembler.sv
`timescale 1ns/10ps

module read_word_assembler (
    input  logic                clk,
    input  logic                rst,
    input  logic                byte_evt_valid_i,
    input  biu_pkg::byte_evt_t  byte_evt_i,
    output logic                done_o,
    output biu_pkg::cpu_word_t  rdata_o
);

    biu_pkg::bus_data_t lo_q;       // first byte of a pair
    biu_pkg::bus_data_t rx_byte;
    biu_pkg::cpu_word_t word_nxt;
    logic               core_evt;

    // inta bytes belong to the vector path
    assign core_evt = byte_evt_valid_i && (byte_evt_i.kind != biu_pkg::int_ack);

    // writes give zero
    assign rx_byte = (byte_evt_i.kind == biu_pkg::mem_read) ? byte_evt_i.data : '0;

    always_comb begin
        if (byte_evt_i.hi) begin
            word_nxt = {rx_byte, lo_q};
        end else begin
            word_nxt = {8'h00, rx_byte};   // first byte starts a fresh word
        end
    end

    always_ff @(posedge clk) begin
        if (core_evt && !byte_evt_i.hi) begin
            lo_q <= rx_byte;
        end
        if (core_evt && byte_evt_i.last) begin
            rdata_o <= word_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done_o <= 1'b0;
        end else begin
            done_o <= core_evt && byte_evt_i.last;
        end
    end

endmodule

// File: biu_top.sv
`timescale 1ns/10ps

module biu_top (
    input  logic                clk,
    input  logic                rst,
    // core side
    input  logic                req_valid_i,
    input  biu_pkg::core_req_t  req_i,
    output logic                busy_o,
    output logic                done_o,
    output biu_pkg::cpu_word_t  rdata_o,
    // interrupt and hold
    input  logic                intr_i,
    output logic                vec_valid_o,
    output biu_pkg::bus_data_t  vec_o,
    input  logic                hold_i,
    output logic                hlda_o,
    // 8088 bus
    input  logic                ready_i,
    input  biu_pkg::bus_data_t  ad_i,
    output biu_pkg::bus_data_t  ad_o,
    output logic                ad_oe_o,
    output biu_pkg::bus_addr_t  a_o,
    output logic                ale_o,
    output logic                rd_n_o,
    output logic                wr_n_o,
    output logic                inta_n_o,
    output logic                den_n_o,
    output logic                dtr_o,
    output logic                iom_o
);

    logic               req_pend;
    biu_pkg::core_req_t req_q;
    logic               ack_pend;
    logic               byte_evt_valid;
    biu_pkg::byte_evt_t byte_evt;

    core_req_port u_req_port (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .byte_evt_valid_i (byte_evt_valid),
        .byte_evt_i       (byte_evt),
        .req_pend_o       (req_pend),
        .req_o            (req_q),
        .busy_o           (busy_o)
    );

    intr_ack_seq u_intr_ack (
        .clk              (clk),
        .rst              (rst),
        .intr_i           (intr_i),
        .byte_evt_valid_i (byte_evt_valid),
        .byte_evt_i       (byte_evt),
        .ack_pend_o       (ack_pend),
        .vec_valid_o      (vec_valid_o),
        .vec_o            (vec_o)
    );

    bus_cycle_ctrl u_bus_ctrl (
        .clk              (clk),
        .rst              (rst),
        .hold_i           (hold_i),
        .ready_i          (ready_i),
        .ad_i             (ad_i),
        .req_pend_i       (req_pend),
        .req_i            (req_q),
        .ack_pend_i       (ack_pend),
        .a_o              (a_o),
        .ale_o            (ale_o),
        .rd_n_o           (rd_n_o),
        .wr_n_o           (wr_n_o),
        .inta_n_o         (inta_n_o),
        .den_n_o          (den_n_o),
        .dtr_o            (dtr_o),
        .iom_o            (iom_o),
        .ad_o             (ad_o),
        .ad_oe_o          (ad_oe_o),
        .hlda_o           (hlda_o),
        .byte_evt_valid_o (byte_evt_valid),
        .byte_evt_o       (byte_evt)
    );

    read_word_assembler u_rd_asm (
        .clk              (clk),
        .rst              (rst),
        .byte_evt_valid_i (byte_evt_valid),
        .byte_evt_i       (byte_evt),
        .done_o           (done_o),
        .rdata_o          (rdata_o)
    );

endmodule

// File: biu_asserts.sv
`timescale 1ns/10ps

module biu_asserts (
    input logic                clk,
    input logic                rst,
    input logic                req_valid_i,
    input logic                busy_o,
    input logic                done_o,
    input logic                vec_valid_o,
    input logic                hlda_o,
    input logic                ready_i,
    input logic                ale_o,
    input logic                rd_n_o,
    input logic                wr_n_o,
    input logic                inta_n_o,
    input logic                den_n_o,
    input logic                dtr_o,
    input logic                ad_oe_o,
    input biu_pkg::bus_state_t bus_state_i
);

    int unsigned fail_cnt = 0;   // failed assertions so far
    logic        strobes_off;

    assign strobes_off = rd_n_o && wr_n_o && inta_n_o;

    ale_in_strobe: assert property (@(posedge clk) disable iff (!rst) ale_o |-> strobes_off)
    else begin
        $error("ale_o high while a strobe is active");
        fail_cnt++;
    end

    // bus fully released while held
    bus_released: assert property (@(posedge clk) disable iff (!rst)
        hlda_o |-> (strobes_off && !ad_oe_o))
    else begin
        $error("bus driven while hlda_o is high");
        fail_cnt++;
    end

    ad_turnaround: assert property (@(posedge clk) disable iff (!rst)
        (!rd_n_o || !inta_n_o) |-> !ad_oe_o)
    else begin
        $error("ad driven during a read or inta strobe");
        fail_cnt++;
    end

    req_when_busy: assert property (@(posedge clk) disable iff (!rst) busy_o |-> !req_valid_i)
    else begin
        $error("request strobe while busy_o is high");
        fail_cnt++;
    end

    // wait state keeps T3 and the read strobe
    wait_state: assert property (@(posedge clk) disable iff (!rst)
        (bus_state_i == biu_pkg::bs_t3 && !ready_i)
        |=> (bus_state_i == biu_pkg::bs_t3 && (!rd_n_o || $past(rd_n_o))))
    else begin
        $error("T3 left or rd_n_o released while ready_i low");
        fail_cnt++;
    end

    reset_values: assert property (@(posedge clk) !rst |-> (!ale_o && strobes_off && den_n_o
        && dtr_o && !ad_oe_o && !hlda_o && !busy_o && !done_o && !vec_valid_o))
    else begin
        $error("output not at its reset value during reset");
        fail_cnt++;
    end

endmodule

// File: tb_biu.sv
`timescale 1ns/10ps

module tb_biu;

    logic               clk = 1'b0;
    logic               rst;
    logic               req_valid_i;
    biu_pkg::core_req_t req_i;
    logic               busy_o, done_o, vec_valid_o, hlda_o;
    biu_pkg::cpu_word_t rdata_o;
    logic               intr_i, hold_i, ready_i;
    biu_pkg::bus_data_t ad_i, ad_o, vec_o;
    biu_pkg::bus_addr_t a_o;
    logic               ad_oe_o, ale_o, rd_n_o, wr_n_o, inta_n_o, den_n_o, dtr_o, iom_o;

    int                 err_cnt = 0;
    int                 tmo_cnt = 0;
    int                 ale_cnt = 0;
    int                 inta_cnt = 0;
    int                 vec_cnt = 0;
    logic               waits_on = 1'b0;     // random wait states
    logic               inta_prev = 1'b1;
    logic               wr_prev = 1'b1;
    logic               exp_iom = 1'b0;      // io/mem space of the current request
    biu_pkg::bus_addr_t addr_lat = '0;
    biu_pkg::bus_data_t exp_vec = '0;
    biu_pkg::bus_addr_t wr_addr_q[$];
    biu_pkg::bus_data_t wr_data_q[$];
    time                t_req;

    biu_top u_dut (.*);

    bind biu_top biu_asserts u_asserts (.*, .bus_state_i(u_bus_ctrl.state_q));

    always #10 clk = ~clk;

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            err_cnt++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic close_run();
        int proto;
        proto = u_dut.u_asserts.fail_cnt;
        $display("errors: data %0d, protocol %0d, timeout %0d", err_cnt, proto, tmo_cnt);
        if (err_cnt == 0 && proto == 0 && tmo_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    function automatic logic level_of(input string name);
        case (name)
            "done": return done_o;
            "free": return !busy_o;
            "vec":  return vec_valid_o;
            "hlda": return hlda_o;
            default: return ale_o;
        endcase
    endfunction

    // polls on the falling edge and gives up after limit cycles
    task automatic wait_until(input string name, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                tmo_cnt++;
                $display("timeout: no %s within %0d cycles at %0t ns", name, limit, $time);
                close_run();
            end
        end while (!level_of(name));
    endtask

    // every memory byte is its address low byte xor 5a
    function automatic biu_pkg::cpu_word_t model_word(input biu_pkg::bus_addr_t addr,
                                                      input logic word);
        biu_pkg::bus_addr_t addr_hi;
        addr_hi = addr + 1;
        return word ? {addr_hi[7:0] ^ 8'h5a, addr[7:0] ^ 8'h5a} : {8'h00, addr[7:0] ^ 8'h5a};
    endfunction

    // bus side model with address latch, read data, vector source and write log
    always @(negedge clk) begin
        if (ale_o) begin
            addr_lat = a_o;
            ale_cnt++;
            check(iom_o == exp_iom, "iom_o does not match the request");
        end
        if (!inta_n_o && inta_prev) begin
            inta_cnt++;
            exp_vec = (inta_cnt == 1) ? 8'h21 : biu_pkg::bus_data_t'($urandom);
        end
        if (!wr_n_o && wr_prev) begin
            wr_addr_q.push_back(addr_lat);
            wr_data_q.push_back(ad_o);
            check(ad_oe_o && dtr_o, "write byte without ad_oe_o and dtr_o high");
        end
        check(den_n_o == (rd_n_o && wr_n_o && inta_n_o), "den_n_o does not follow the strobes");
        if (!rd_n_o || !inta_n_o) begin
            check(!dtr_o, "dtr_o high during a read or inta strobe");
        end
        if (vec_valid_o) begin
            vec_cnt++;
        end
        ad_i = !inta_n_o ? exp_vec : (addr_lat[7:0] ^ 8'h5a);
        ready_i = waits_on ? (($urandom % 3) != 0) : 1'b1;
        inta_prev = inta_n_o;
        wr_prev = wr_n_o;
    end

    task automatic send_req(input biu_pkg::bus_addr_t addr, input biu_pkg::cpu_word_t wdata,
                            input logic we, input logic word);
        wait_until("free", 100);
        exp_iom = 1'($urandom);
        req_i = '{addr: addr, wdata: wdata, we: we, word: word, iom: exp_iom};
        req_valid_i = 1'b1;
        t_req = $time;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic run_read(input logic word);
        biu_pkg::bus_addr_t addr;
        int                 lat;
        addr = biu_pkg::bus_addr_t'($urandom);
        ale_cnt = 0;
        send_req(addr, '0, 1'b0, word);
        wait_until("done", 200);
        lat = ($time - t_req) / 20;
        check(rdata_o == model_word(addr, word),
              $sformatf("read %05h gave %04h", addr, rdata_o));
        check(ale_cnt == (word ? 2 : 1), $sformatf("%0d ale pulses for one read", ale_cnt));
        check(!busy_o, "busy_o still high with done_o");
        check(waits_on || lat == (word ? 10 : 6), $sformatf("latency %0d cycles", lat));
    endtask

    task automatic run_write(input logic word);
        biu_pkg::bus_addr_t addr;
        biu_pkg::cpu_word_t wdata;
        addr = biu_pkg::bus_addr_t'($urandom);
        wdata = biu_pkg::cpu_word_t'($urandom);
        wr_addr_q.delete();
        wr_data_q.delete();
        send_req(addr, wdata, 1'b1, word);
        wait_until("done", 200);
        check(rdata_o == '0, $sformatf("write left rdata_o at %04h", rdata_o));
        check(wr_data_q.size() == (word ? 2 : 1), "wrong number of write bytes");
        check(wr_addr_q[0] == addr && wr_data_q[0] == wdata[7:0], "low write byte wrong");
        if (word) begin
            check(wr_addr_q[1] == biu_pkg::bus_addr_t'(addr + 1)
                  && wr_data_q[1] == wdata[15:8], "high write byte wrong");
        end
    endtask

    initial begin
        biu_pkg::bus_addr_t hold_addr;
        void'($urandom(32'hfdca));
        rst = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        intr_i = 1'b0;
        hold_i = 1'b0;
        ready_i = 1'b1;
        ad_i = '0;
        repeat (4) @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < 6; i++) begin
            run_read(i[0]);
            run_write(i[0]);
        end
        waits_on = 1'b1;
        for (int i = 0; i < 8; i++) begin
            run_read(i[0]);
        end
        waits_on = 1'b0;

        // intr held high gives one acknowledge only
        inta_cnt = 0;
        vec_cnt = 0;
        intr_i = 1'b1;
        wait_until("vec", 100);
        check(vec_o == exp_vec, $sformatf("vector %02h, expected %02h", vec_o, exp_vec));
        repeat (20) @(negedge clk);
        intr_i = 1'b0;
        repeat (5) @(negedge clk);
        check(inta_cnt == 2 && vec_cnt == 1, $sformatf("%0d inta, %0d vec", inta_cnt, vec_cnt));

        // hold during a word read and a request queued behind hold
        hold_addr = biu_pkg::bus_addr_t'($urandom);
        send_req(hold_addr, '0, 1'b0, 1'b1);
        wait_until("ale", 20);
        hold_i = 1'b1;
        wait_until("done", 100);
        check(!hlda_o && rdata_o == model_word(hold_addr, 1'b1), "hold broke the word read");
        wait_until("hlda", 10);
        hold_addr = biu_pkg::bus_addr_t'($urandom);
        send_req(hold_addr, '0, 1'b0, 1'b0);
        repeat (10) @(negedge clk);
        check(busy_o && hlda_o, "request served during hold");
        hold_i = 1'b0;
        @(negedge clk);
        check(!hlda_o, "hlda_o did not drop one cycle after hold_i");
        wait_until("done", 50);
        check(rdata_o == model_word(hold_addr, 1'b0), "read after hold wrong");
        close_run();
    end

endmodule

// File: biu.f
biu_pkg.sv
core_req_port.sv
intr_ack_seq.sv
bus_cycle_ctrl.sv
read_word_assembler.sv
biu_top.sv
biu_asserts.sv
tb_biu.sv
